// ==== common/ram_if.sv ====
`default_nettype none

interface ram_if
    import soc_pkg::*;
();

    ram_addr_t addr;    // Word address inside the RAM
    data_t     wdata;   // Write data
    logic      we;      // One-cycle write pulse
    data_t     rdata;   // Registered read data

    modport ctrl (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // Address and data widths
    localparam int RAM_ADDR_W = 10;               // Word address inside one RAM
    localparam int WB_ADDR_W  = RAM_ADDR_W + 1;   // One region bit on top
    localparam int DATA_W     = 32;               // Bus and RAM word width
    localparam int RAM_WORDS  = 1 << RAM_ADDR_W;  // Depth of each RAM

    // Region codes held in the top Wishbone address bit
    localparam logic IRAM = 1'b0;                 // Instruction RAM
    localparam logic DRAM = 1'b1;                 // Data RAM

    typedef logic [WB_ADDR_W-1:0]  wb_addr_t;     // Wishbone word address
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;    // Address within one RAM
    typedef logic [DATA_W-1:0]     data_t;        // One data word

    // Bridge RAM sequence
    typedef enum logic [1:0] {
        RAM_IDLE,                                 // No access in flight
        RAM_REQ,                                  // Address and write enable at the RAM
        RAM_RESP                                  // Read data valid at the RAM output
    } ram_state_e;

    // Bridge Wishbone sequence
    typedef enum logic {
        WB_IDLE,                                  // Waiting for a RAM response
        WB_RESP                                   // Ack high for one cycle
    } wb_state_e;

    // Arbiter ownership
    typedef enum logic {
        ARB_IDLE,                                 // Bus free until the next grant
        ARB_BUSY                                  // Bus locked to the owner
    } arb_state_e;

endpackage

`default_nettype wire

// ==== common/wb_if.sv ====
`default_nettype none

interface wb_if
    import soc_pkg::*;
();

    logic     cyc;    // Bus cycle in progress
    logic     stb;    // Transfer request
    logic     we;     // High for write, low for read
    wb_addr_t addr;   // Word address with region bit
    data_t    wdata;  // Write data
    data_t    rdata;  // Read data valid with ack
    logic     ack;    // One-cycle completion pulse

    modport master (
        output cyc,
        output stb,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

// ==== hw/mem_subsys_top.sv ====
`default_nettype none

module mem_subsys_top
    import soc_pkg::*;
(
    input  wire           ram_clk_i,     // System clock
    input  wire           rst_ni,        // Async active-low reset

    // Master 0 for instruction fetch
    input  wire           m0_cyc_i,
    input  wire           m0_stb_i,
    input  wire           m0_we_i,
    input  wire wb_addr_t m0_addr_i,
    input  wire data_t    m0_wdata_i,
    output data_t         m0_rdata_o,
    output logic          m0_ack_o,

    // Master 1 for load/store
    input  wire           m1_cyc_i,
    input  wire           m1_stb_i,
    input  wire           m1_we_i,
    input  wire wb_addr_t m1_addr_i,
    input  wire data_t    m1_wdata_i,
    output data_t         m1_rdata_o,
    output logic          m1_ack_o
);

    wb_if  m0_bus ();      // Master 0 side of the arbiter
    wb_if  m1_bus ();      // Master 1 side of the arbiter
    wb_if  sys_bus ();     // Arbiter to bridge
    ram_if iram_bus ();    // Bridge to IRAM
    ram_if dram_bus ();    // Bridge to DRAM

    assign m0_bus.cyc   = m0_cyc_i;
    assign m0_bus.stb   = m0_stb_i;
    assign m0_bus.we    = m0_we_i;
    assign m0_bus.addr  = m0_addr_i;
    assign m0_bus.wdata = m0_wdata_i;
    assign m0_rdata_o   = m0_bus.rdata;
    assign m0_ack_o     = m0_bus.ack;

    assign m1_bus.cyc   = m1_cyc_i;
    assign m1_bus.stb   = m1_stb_i;
    assign m1_bus.we    = m1_we_i;
    assign m1_bus.addr  = m1_addr_i;
    assign m1_bus.wdata = m1_wdata_i;
    assign m1_rdata_o   = m1_bus.rdata;
    assign m1_ack_o     = m1_bus.ack;

    wb_arbiter u_arbiter (
        .ram_clk_i (ram_clk_i),
        .rst_ni    (rst_ni),
        .m0_bus    (m0_bus.slave),
        .m1_bus    (m1_bus.slave),
        .sys_bus   (sys_bus.master)
    );

    wb_ram_interface u_bridge (
        .ram_clk_i (ram_clk_i),
        .rst_ni    (rst_ni),
        .wb        (sys_bus.slave),
        .iram      (iram_bus.ctrl),
        .dram      (dram_bus.ctrl)
    );

    sp_ram u_iram (
        .ram_clk_i (ram_clk_i),
        .mem       (iram_bus.mem)
    );

    sp_ram u_dram (
        .ram_clk_i (ram_clk_i),
        .mem       (dram_bus.mem)
    );

endmodule

`default_nettype wire

// ==== hw/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter
    import soc_pkg::*;
(
    input  wire   ram_clk_i,   // System clock
    input  wire   rst_ni,      // Async active-low reset
    wb_if.slave   m0_bus,      // Instruction-fetch master
    wb_if.slave   m1_bus,      // Load/store master
    wb_if.master  sys_bus      // Shared bus towards the bridge
);

    arb_state_e arb_state;
    arb_state_e arb_next_state;
    logic       owner_q;       // Current owner where 1 means m1
    logic       last_q;        // Master served most recently
    logic       any_req;       // At least one master has cyc high
    logic       grant_m1;      // Winner of a grant taken this cycle
    logic       owner_cyc;     // Owner still holds its cycle
    logic       m0_sel;        // m0 routed to the shared bus
    logic       m1_sel;        // m1 routed to the shared bus

    assign any_req   = m0_bus.cyc | m1_bus.cyc;
    // On a tie the master not served last wins
    assign grant_m1  = m1_bus.cyc & (~m0_bus.cyc | ~last_q);
    assign owner_cyc = owner_q ? m1_bus.cyc : m0_bus.cyc;

    assign m0_sel = (arb_state == ARB_BUSY) & ~owner_q;
    assign m1_sel = (arb_state == ARB_BUSY) & owner_q;

    always_comb begin : arb_next
        arb_next_state = arb_state;
        case (arb_state)
            ARB_IDLE: begin
                if (any_req)
                    arb_next_state = ARB_BUSY;
            end
            ARB_BUSY: begin
                if (!owner_cyc)                   // Owner ended its cycle
                    arb_next_state = ARB_IDLE;
            end
            default: arb_next_state = ARB_IDLE;
        endcase
    end : arb_next

    always_ff @(posedge ram_clk_i or negedge rst_ni) begin : arb_seq
        if (!rst_ni) begin
            arb_state <= ARB_IDLE;
            owner_q   <= 1'b0;
            last_q    <= 1'b1;                    // m0 wins the first tie
        end else begin
            arb_state <= arb_next_state;
            if (arb_state == ARB_IDLE && any_req)
                owner_q <= grant_m1;              // Lock the grant
            if (arb_state == ARB_BUSY && !owner_cyc)
                last_q  <= owner_q;               // Remember who was served
        end
    end : arb_seq

    // Request path qualified by the grant
    assign sys_bus.cyc   = (m0_sel & m0_bus.cyc) | (m1_sel & m1_bus.cyc);
    assign sys_bus.stb   = (m0_sel & m0_bus.stb) | (m1_sel & m1_bus.stb);
    assign sys_bus.we    = (m0_sel & m0_bus.we)  | (m1_sel & m1_bus.we);
    assign sys_bus.addr  = owner_q ? m1_bus.addr  : m0_bus.addr;
    assign sys_bus.wdata = owner_q ? m1_bus.wdata : m0_bus.wdata;

    // Response path seen only by the owner
    assign m0_bus.ack   = m0_sel & sys_bus.ack;
    assign m1_bus.ack   = m1_sel & sys_bus.ack;
    assign m0_bus.rdata = m0_sel ? sys_bus.rdata : '0;
    assign m1_bus.rdata = m1_sel ? sys_bus.rdata : '0;

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
common/soc_pkg.sv
common/wb_if.sv
common/ram_if.sv
hw/wb_arbiter.sv
wb_ram/sp_ram.sv
wb_ram/wb_ram_interface.sv
hw/mem_subsys_top.sv
tb/mem_subsys_props.sv
tb/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_subsys_tb -f mem_subsys.f \
    --Mdir obj_dir -o Vmem_subsys_tb

status=0
./obj_dir/Vmem_subsys_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Test passed" sim.log; then
    echo "Simulation did not complete normally"
    exit 1
fi
echo "Simulation finished without failures"

// ==== tb/mem_subsys_props.sv ====
`default_nettype none

module mem_subsys_props (
    input wire ram_clk_i,
    input wire rst_ni,
    input wire m0_cyc_i,
    input wire m0_stb_i,
    input wire m0_ack_i,
    input wire m1_cyc_i,
    input wire m1_stb_i,
    input wire m1_ack_i,
    input wire iram_we_i,
    input wire dram_we_i
);
    timeunit 1ns;
    timeprecision 1ps;

    m0_ack_pulse: assert property (@(posedge ram_clk_i) disable iff (!rst_ni)
        m0_ack_i |=> !m0_ack_i)
        else $error("m0 ack high for more than one cycle");

    m1_ack_pulse: assert property (@(posedge ram_clk_i) disable iff (!rst_ni)
        m1_ack_i |=> !m1_ack_i)
        else $error("m1 ack high for more than one cycle");

    ack_exclusive: assert property (@(posedge ram_clk_i) disable iff (!rst_ni)
        !(m0_ack_i && m1_ack_i))
        else $error("Both masters acknowledged in the same cycle");

    // Ack only inside the master's own bus cycle
    m0_ack_in_cycle: assert property (@(posedge ram_clk_i) disable iff (!rst_ni)
        m0_ack_i |-> (m0_cyc_i && m0_stb_i))
        else $error("m0 ack without m0 cyc and stb");

    m1_ack_in_cycle: assert property (@(posedge ram_clk_i) disable iff (!rst_ni)
        m1_ack_i |-> (m1_cyc_i && m1_stb_i))
        else $error("m1 ack without m1 cyc and stb");

    we_exclusive: assert property (@(posedge ram_clk_i) disable iff (!rst_ni)
        !(iram_we_i && dram_we_i))
        else $error("IRAM and DRAM written in the same cycle");

endmodule

bind mem_subsys_top mem_subsys_props u_props (
    .ram_clk_i (ram_clk_i),
    .rst_ni    (rst_ni),
    .m0_cyc_i  (m0_cyc_i),
    .m0_stb_i  (m0_stb_i),
    .m0_ack_i  (m0_ack_o),
    .m1_cyc_i  (m1_cyc_i),
    .m1_stb_i  (m1_stb_i),
    .m1_ack_i  (m1_ack_o),
    .iram_we_i (iram_bus.we),
    .dram_we_i (dram_bus.we)
);

`default_nettype wire

// ==== tb/mem_subsys_tb.sv ====
`default_nettype none

module mem_subsys_tb
    import soc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h16b865f7;
    localparam int CONT_OPS    = 8;     // Per master in the contention test
    localparam int RAND_OPS    = 200;   // Per master in random traffic
    localparam int TOTAL_XFERS = 2 + 4 + 1 + 2 * CONT_OPS + 2 * RAND_OPS;
    localparam int TIMEOUT_NS  = TOTAL_XFERS * 12 * 8 + 200;
    localparam int ACK_WAIT    = 40;    // Cycles until a missing ack is reported
    // Negedges after the drive, grant and accept edges and the two bridge edges
    localparam int ISO_LAT     = 5;

    logic     ram_clk_i = 1'b0;
    logic     rst_ni;
    logic     m0_cyc_i;
    logic     m0_stb_i;
    logic     m0_we_i;
    wb_addr_t m0_addr_i;
    data_t    m0_wdata_i;
    data_t    m0_rdata_o;
    logic     m0_ack_o;
    logic     m1_cyc_i;
    logic     m1_stb_i;
    logic     m1_we_i;
    wb_addr_t m1_addr_i;
    data_t    m1_wdata_i;
    data_t    m1_rdata_o;
    logic     m1_ack_o;

    data_t       model_mem [1 << WB_ADDR_W];  // Indexed by full Wishbone address
    bit          written [1 << WB_ADDR_W];    // Word holds a known value
    logic [31:0] rng_state [2];               // One generator per master
    bit          last_served;                 // Master of the latest ack
    bit          ack_order [$];               // Masters in ack order
    int          ack_cnt [2];
    int          checks;
    int          errors;

    always #4 ram_clk_i = ~ram_clk_i;         // 8 ns period

    mem_subsys_top dut_i (
        .ram_clk_i  (ram_clk_i),
        .rst_ni     (rst_ni),
        .m0_cyc_i   (m0_cyc_i),
        .m0_stb_i   (m0_stb_i),
        .m0_we_i    (m0_we_i),
        .m0_addr_i  (m0_addr_i),
        .m0_wdata_i (m0_wdata_i),
        .m0_rdata_o (m0_rdata_o),
        .m0_ack_o   (m0_ack_o),
        .m1_cyc_i   (m1_cyc_i),
        .m1_stb_i   (m1_stb_i),
        .m1_we_i    (m1_we_i),
        .m1_addr_i  (m1_addr_i),
        .m1_wdata_i (m1_wdata_i),
        .m1_rdata_o (m1_rdata_o),
        .m1_ack_o   (m1_ack_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(input bit m, output logic [31:0] r);
        rng_state[m] = xorshift32(rng_state[m]);
        r = rng_state[m];
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%s: done, %0d errors", name, errors - err_start);
    endtask

    // Request lines of one master driven on the rising edge
    task automatic drive_req(input bit m, input logic req, input logic we,
                             input wb_addr_t a, input data_t d);
        if (m) begin
            m1_cyc_i   <= req;
            m1_stb_i   <= req;
            m1_we_i    <= we;
            m1_addr_i  <= a;
            m1_wdata_i <= d;
        end else begin
            m0_cyc_i   <= req;
            m0_stb_i   <= req;
            m0_we_i    <= we;
            m0_addr_i  <= a;
            m0_wdata_i <= d;
        end
    endtask

    // Writes update the model and reads are checked in ack order
    task automatic apply_model(input bit m, input logic we, input wb_addr_t a,
                               input data_t d, input data_t rd);
        if (we) begin
            model_mem[a] = d;
            written[a]   = 1'b1;
        end else if (written[a]) begin
            check_value(m ? "m1_rdata_o" : "m0_rdata_o", model_mem[a], rd);
        end
        ack_order.push_back(m);
        last_served = m;
    endtask

    // One Wishbone access where lat counts negedges from the drive edge to ack
    task automatic bus_xfer(input bit m, input logic we, input wb_addr_t a,
                            input data_t d, output data_t rd, output int lat);
        logic got;
        @(posedge ram_clk_i);
        drive_req(m, 1'b1, we, a, d);
        got = 1'b0;
        lat = 0;
        while (!got && lat < ACK_WAIT) begin
            @(negedge ram_clk_i);
            got = m ? m1_ack_o : m0_ack_o;
            lat++;
        end
        rd = m ? m1_rdata_o : m0_rdata_o;
        if (got) begin
            apply_model(m, we, a, d, rd);
        end else begin
            errors++;
            $display("Master m%0d got no ack within %0d cycles at %0t ns", m, ACK_WAIT, $time);
        end
        @(posedge ram_clk_i);
        drive_req(m, 1'b0, 1'b0, a, d);                // Drop cyc and stb
    endtask

    task automatic contend(input bit m);
        data_t rd;
        int    lat;
        for (int i = 0; i < CONT_OPS; i++) begin      // Writes first and then reads back
            bus_xfer(m, i < CONT_OPS / 2, {m, ram_addr_t'(64 + i % 4)},
                     {8'h5a, 7'd0, m, 16'(i)}, rd, lat);
        end
    endtask

    task automatic random_master(input bit m, input int ops);
        logic [31:0] r;
        logic [31:0] d;
        data_t       rd;
        int          lat;
        for (int i = 0; i < ops; i++) begin
            next_rand(m, r);
            next_rand(m, d);
            repeat (r[7:6]) @(posedge ram_clk_i);     // Idle gap of 0 to 3 cycles
            bus_xfer(m, r[5], {r[0], 6'd0, r[4:1]}, d, rd, lat);   // 16 words per region
        end
    endtask

    always @(negedge ram_clk_i) begin : ack_count
        if (m0_ack_o)
            ack_cnt[0] += 1;
        if (m1_ack_o)
            ack_cnt[1] += 1;
    end : ack_count

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Simulation timed out after %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end : watchdog

    initial begin : main
        int    err_start;
        int    lat;
        int    cnt0;
        int    cnt1;
        bit    first;
        data_t rd;
        rng_state[0] = SEED;
        rng_state[1] = ~SEED;
        rst_ni = 1'b0;
        drive_req(1'b0, 1'b0, 1'b0, '0, '0);
        drive_req(1'b1, 1'b0, 1'b0, '0, '0);
        repeat (10) @(posedge ram_clk_i);
        rst_ni <= 1'b1;

        err_start = errors;                            // Idle acks then IRAM write and read
        repeat (8) begin
            @(negedge ram_clk_i);
            check_value("m0_ack_o", '0, data_t'(m0_ack_o));
            check_value("m1_ack_o", '0, data_t'(m1_ack_o));
        end
        bus_xfer(1'b0, 1'b1, {IRAM, ram_addr_t'(3)}, 32'hc0de_0003, rd, lat);
        bus_xfer(1'b0, 1'b0, {IRAM, ram_addr_t'(3)}, '0, rd, lat);
        check_value("m0_rdata_o", 32'hc0de_0003, rd);
        report_test("test 1 idle and IRAM write/read", err_start);

        err_start = errors;                            // Same low address in both regions
        bus_xfer(1'b1, 1'b1, {IRAM, ram_addr_t'(21)}, 32'h1111_0015, rd, lat);
        bus_xfer(1'b1, 1'b1, {DRAM, ram_addr_t'(21)}, 32'h2222_0015, rd, lat);
        bus_xfer(1'b1, 1'b0, {IRAM, ram_addr_t'(21)}, '0, rd, lat);
        check_value("m1_rdata_o", 32'h1111_0015, rd);
        bus_xfer(1'b1, 1'b0, {DRAM, ram_addr_t'(21)}, '0, rd, lat);
        check_value("m1_rdata_o", 32'h2222_0015, rd);
        report_test("test 2 region separation", err_start);

        err_start = errors;                            // Isolated latency and a single pulse
        bus_xfer(1'b0, 1'b0, {DRAM, ram_addr_t'(21)}, '0, rd, lat);
        check_value("m0_ack_o latency", data_t'(ISO_LAT), data_t'(lat));
        check_value("m0_rdata_o", 32'h2222_0015, rd);
        repeat (8) begin
            @(negedge ram_clk_i);
            check_value("m0_ack_o", '0, data_t'(m0_ack_o));
        end
        report_test("test 3 bridge latency", err_start);

        err_start = errors;                            // Both masters request together
        ack_order.delete();
        first = !last_served;                          // Not served last wins the tie
        cnt0 = ack_cnt[0];
        cnt1 = ack_cnt[1];
        fork
            contend(1'b0);
            contend(1'b1);
        join
        @(posedge ram_clk_i);
        check_value("m0_ack_o count", data_t'(CONT_OPS), data_t'(ack_cnt[0] - cnt0));
        check_value("m1_ack_o count", data_t'(CONT_OPS), data_t'(ack_cnt[1] - cnt1));
        foreach (ack_order[i])
            check_value("ack owner", data_t'(int'(first) ^ (i % 2)), data_t'(ack_order[i]));
        report_test("test 4 contention", err_start);

        err_start = errors;
        fork
            random_master(1'b0, RAND_OPS);
            random_master(1'b1, RAND_OPS);
        join
        report_test("test 5 random traffic", err_start);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end : main

endmodule

`default_nettype wire

// ==== wb_ram/sp_ram.sv ====
`default_nettype none

module sp_ram
    import soc_pkg::*;
(
    input  wire  ram_clk_i,   // System clock
    ram_if.mem   mem          // Port from the bridge
);

    data_t ram_q [RAM_WORDS];  // Storage undefined until written

    // Write on the pulse while the read register follows the address
    always_ff @(posedge ram_clk_i) begin : ram_access
        if (mem.we)
            ram_q[mem.addr] <= mem.wdata;
        mem.rdata <= ram_q[mem.addr];          // Old word on a write cycle
    end : ram_access

endmodule

`default_nettype wire

// ==== wb_ram/wb_ram_interface.sv ====
`default_nettype none

module wb_ram_interface
    import soc_pkg::*;
(
    input  wire   ram_clk_i,   // System clock
    input  wire   rst_ni,      // Async active-low reset
    wb_if.slave   wb,          // Shared Wishbone bus
    ram_if.ctrl   iram,        // Instruction RAM port
    ram_if.ctrl   dram         // Data RAM port
);

    ram_state_e ram_state;
    ram_state_e ram_next_state;
    wb_state_e  wb_state;
    wb_state_e  wb_next_state;

    logic      bus_req;        // cyc and stb both high
    logic      accept;         // New access starts at this edge
    logic      ram_resp;       // RAM output holds the requested word
    logic      ack_set;        // Ack rises at this edge
    logic      region;         // Region bit of the live address
    logic      region_q;       // Region of the access in flight
    logic      iram_we_q;
    logic      dram_we_q;
    logic      ack_q;
    ram_addr_t addr_q;
    data_t     wdata_q;
    data_t     rdata_q;

    assign bus_req  = wb.cyc & wb.stb;
    assign region   = wb.addr[RAM_ADDR_W];
    assign ram_resp = (ram_state == RAM_RESP);
    // Refused during WB_RESP so a strobe held past ack starts nothing
    assign accept   = bus_req & (ram_state == RAM_IDLE) & (wb_state == WB_IDLE);
    assign ack_set  = bus_req & ram_resp & (wb_state == WB_IDLE);

    always_comb begin : ram_next
        ram_next_state = RAM_IDLE;
        case (ram_state)
            RAM_IDLE: begin
                if (accept)
                    ram_next_state = RAM_REQ;
            end
            RAM_REQ:  ram_next_state = RAM_RESP;   // RAM writes or reads here
            RAM_RESP: ram_next_state = RAM_IDLE;   // Ack is issued on this edge
            default:  ram_next_state = RAM_IDLE;
        endcase
    end : ram_next

    always_ff @(posedge ram_clk_i or negedge rst_ni) begin : ram_seq
        if (!rst_ni) begin
            ram_state <= RAM_IDLE;
            iram_we_q <= 1'b0;
            dram_we_q <= 1'b0;
            region_q  <= IRAM;
        end else begin
            ram_state <= ram_next_state;
            iram_we_q <= accept & wb.we & (region == IRAM);   // One-cycle pulse
            dram_we_q <= accept & wb.we & (region == DRAM);
            if (accept)
                region_q <= region;
        end
    end : ram_seq

    // Request payload captured at acceptance
    always_ff @(posedge ram_clk_i) begin : req_capture
        if (accept) begin
            addr_q  <= wb.addr[RAM_ADDR_W-1:0];
            wdata_q <= wb.wdata;
        end
    end : req_capture

    always_comb begin : wb_next
        wb_next_state = WB_IDLE;
        case (wb_state)
            WB_IDLE: begin
                if (ack_set)
                    wb_next_state = WB_RESP;
            end
            WB_RESP: wb_next_state = WB_IDLE;     // Ack lasts one cycle
            default: wb_next_state = WB_IDLE;
        endcase
    end : wb_next

    always_ff @(posedge ram_clk_i or negedge rst_ni) begin : wb_seq
        if (!rst_ni) begin
            wb_state <= WB_IDLE;
            ack_q    <= 1'b0;
        end else begin
            wb_state <= wb_next_state;
            ack_q    <= ack_set;
        end
    end : wb_seq

    // Read word from the region of the access
    always_ff @(posedge ram_clk_i) begin : rdata_capture
        if (ack_set)
            rdata_q <= (region_q == DRAM) ? dram.rdata : iram.rdata;
    end : rdata_capture

    // Both RAMs share address and data with one write enable each
    assign iram.addr  = addr_q;
    assign iram.wdata = wdata_q;
    assign iram.we    = iram_we_q;
    assign dram.addr  = addr_q;
    assign dram.wdata = wdata_q;
    assign dram.we    = dram_we_q;

    assign wb.ack   = ack_q;
    assign wb.rdata = rdata_q;

endmodule

`default_nettype wire
